// File: cache_subsystem.f
+incdir+src
src/cache_pkg.sv
src/mem_pkg.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_lru.sv
src/cache_ctrl.sv
src/main_memory.sv
src/cache_subsystem.sv
sim/tb_cache_subsystem.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cache_subsystem -f cache_subsystem.f -o tb_cache_subsystem

# the simulator exits nonzero on failure, the log decides
./obj_dir/tb_cache_subsystem | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// File: sim/tb_cache_subsystem.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache_subsystem;
	import cache_pkg::*;

	localparam int SETS = 1 << `SET_BITS;
	localparam int MEM_WORDS = 1 << `MEM_IDX_BITS;
	localparam int CYCLES_PER_ENTRY = 2 * `MEM_LATENCY + 10;

	// expected hit column, EXP_ANY leaves the hit flag to the model alone
	localparam logic [1:0] EXP_MISS = 2'd0;
	localparam logic [1:0] EXP_HIT = 2'd1;
	localparam logic [1:0] EXP_ANY = 2'd2;

	typedef struct packed {
		logic       write;
		logic       byte_op;
		addr_t      addr;
		word_t      wdata;
		logic [1:0] exp_hit;
	} entry_t;

	logic       clk_i;
	logic       rst_n_i;
	logic       req_valid_i;
	cache_req_t req_i;
	logic       ready_o;
	logic       rsp_valid_o;
	cache_rsp_t rsp_o;

	entry_t      stim_q[$];
	int unsigned cycle_cnt = 0;
	int unsigned cycle_limit;

	// reference model, memory plus tag/valid/age per set and way
	word_t ref_mem [MEM_WORDS];
	tag_t  ref_tag [SETS][`WAYS];
	logic  ref_valid [SETS][`WAYS];
	age_t  ref_age [SETS][`WAYS];

	cache_subsystem DUT (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.ready_o     (ready_o),
		.rsp_valid_o (rsp_valid_o),
		.rsp_o       (rsp_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp)
			report_failure($sformatf("FAILED at %0t: %s expected %h, got %h",
				$time, name, exp, act));
	endtask

	task automatic check_hit(input string name, input logic exp, input logic act);
		if (act !== exp)
			report_failure($sformatf("FAILED at %0t: %s expected %b, got %b",
				$time, name, exp, act));
	endtask

	always @(posedge clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
			report_failure($sformatf("timeout: run did not finish within %0d cycles",
				cycle_limit));
	end

	// -1 when no valid way holds the tag
	function automatic int find_way(input set_t s, input tag_t t);
		int found;
		found = -1;
		for (int w = 0; w < `WAYS; w++) begin
			if (found < 0 && ref_valid[s][w] && ref_tag[s][w] == t)
				found = w;
		end
		return found;
	endfunction

	// first invalid way, else first way with age 0
	function automatic way_t pick_victim(input set_t s);
		int pick;
		pick = -1;
		for (int w = 0; w < `WAYS; w++) begin
			if (pick < 0 && !ref_valid[s][w])
				pick = w;
		end
		for (int w = 0; w < `WAYS; w++) begin
			if (pick < 0 && ref_age[s][w] == 0)
				pick = w;
		end
		if (pick < 0)
			pick = 0;
		return way_t'(pick);
	endfunction

	task automatic age_touch(input set_t s, input way_t way);
		for (int w = 0; w < `WAYS; w++) begin
			if (w == int'(way))
				ref_age[s][w] = 2'd3;
			else if (ref_age[s][w] != 0)
				ref_age[s][w] = ref_age[s][w] - 2'd1;
		end
	endtask

	// expected response for one entry, then advance the model
	task automatic predict(input entry_t e, output logic hit, output word_t rdata);
		set_t        s;
		tag_t        t;
		int          w;
		way_t        v;
		int unsigned idx;
		int          lane;
		s = e.addr[`SET_BITS+1:2];
		t = e.addr[31:`SET_BITS+2];
		idx = e.addr[`MEM_IDX_BITS+1:2];
		lane = e.addr[1:0];
		w = find_way(s, t);
		hit = (w >= 0);
		if (e.write) begin
			rdata = '0;
			if (e.byte_op)
				ref_mem[idx][lane*8 +: 8] = e.wdata[7:0];
			else
				ref_mem[idx] = e.wdata;
			if (hit)
				age_touch(s, way_t'(w));
		end else begin
			rdata = ref_mem[idx];
			if (hit) begin
				age_touch(s, way_t'(w));
			end else begin
				v = pick_victim(s);
				ref_tag[s][v] = t;
				ref_valid[s][v] = 1'b1;
				age_touch(s, v);
			end
		end
	endtask

	task automatic add_entry(input logic wr, input logic bop, input addr_t a, input word_t d,
			input logic [1:0] eh);
		entry_t e;
		e.write = wr;
		e.byte_op = bop;
		e.addr = a;
		e.wdata = d;
		e.exp_hit = eh;
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		int unsigned r;
		logic        wr;
		logic        bop;
		addr_t       a;
		// cold miss returns zero, repeat hits
		add_entry(0, 0, 'h100, '0, EXP_MISS);
		add_entry(0, 0, 'h100, '0, EXP_HIT);
		// store miss does not allocate
		add_entry(1, 0, 'h200, 32'hdead_beef, EXP_MISS);
		add_entry(0, 0, 'h200, '0, EXP_MISS);
		add_entry(0, 0, 'h200, '0, EXP_HIT);
		// store hit, then push 0x200 out of set 0
		add_entry(1, 0, 'h200, $urandom(), EXP_HIT);
		add_entry(0, 0, 'h200, '0, EXP_HIT);
		add_entry(0, 0, 'h300, '0, EXP_MISS);
		add_entry(0, 0, 'h400, '0, EXP_MISS);
		add_entry(0, 0, 'h500, '0, EXP_MISS);
		add_entry(0, 0, 'h600, '0, EXP_MISS);
		add_entry(0, 0, 'h200, '0, EXP_MISS);
		add_entry(0, 0, 'h200, '0, EXP_HIT);
		// byte lanes on a cached word
		for (int b = 0; b < 4; b++)
			add_entry(1, 1, addr_t'('h200 + b), $urandom(), EXP_HIT);
		add_entry(0, 0, 'h200, '0, EXP_HIT);
		// byte store to memory only
		add_entry(1, 1, 'h7f1, 32'h0000_005a, EXP_MISS);
		add_entry(0, 0, 'h7f0, '0, EXP_MISS);
		add_entry(0, 0, 'h7f0, '0, EXP_HIT);
		// evict 0x200 so the reload shows the memory copy
		add_entry(0, 0, 'h700, '0, EXP_MISS);
		add_entry(0, 0, 'h800, '0, EXP_MISS);
		add_entry(0, 0, 'h900, '0, EXP_MISS);
		add_entry(0, 0, 'ha00, '0, EXP_MISS);
		add_entry(0, 0, 'h200, '0, EXP_MISS);
		// five tags in set 5, the first one is the victim
		for (int t = 0; t < 5; t++)
			add_entry(0, 0, addr_t'('h014 + t * 'h40), '0, EXP_MISS);
		add_entry(0, 0, 'h014, '0, EXP_MISS);
		// refreshed way survives the next fill
		add_entry(0, 0, 'h094, '0, EXP_HIT);
		add_entry(0, 0, 'h154, '0, EXP_MISS);
		add_entry(0, 0, 'h094, '0, EXP_HIT);
		add_entry(0, 0, 'h0d4, '0, EXP_MISS);
		// random mix over 64 word addresses in sets 0, 4, 8 and 12
		for (int i = 0; i < 48; i++) begin
			r = $urandom();
			wr = r[0];
			bop = wr && r[1];
			a = addr_t'((r[13:8] % 64) << 4);
			if (bop)
				a[1:0] = r[5:4];
			add_entry(wr, bop, a, $urandom(), EXP_ANY);
		end
	endtask

	initial begin
		entry_t e;
		logic   exp_hit;
		word_t  exp_rdata;
		rst_n_i = 1'b0;
		req_valid_i = 1'b0;
		req_i = '0;
		cycle_limit = 0;
		void'($urandom(32'h415b_286b));
		for (int i = 0; i < MEM_WORDS; i++)
			ref_mem[i] = '0;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < `WAYS; w++) begin
				ref_tag[s][w] = '0;
				ref_valid[s][w] = 1'b0;
				ref_age[s][w] = '0;
			end
		end
		build_table();
		cycle_limit = (stim_q.size() + 1) * CYCLES_PER_ENTRY;

		repeat (2) @(negedge clk_i);
		rst_n_i = 1'b1;
		@(negedge clk_i);
		if (ready_o !== 1'b1)
			report_failure("ready_o is not high after reset");
		if (rsp_valid_o !== 1'b0)
			report_failure("rsp_valid_o is not low after reset");

		foreach (stim_q[i]) begin
			e = stim_q[i];
			predict(e, exp_hit, exp_rdata);
			while (!ready_o)
				@(negedge clk_i);
			req_i.addr = e.addr;
			req_i.wdata = e.wdata;
			req_i.write = e.write;
			req_i.byte_op = e.byte_op;
			req_valid_i = 1'b1;
			@(negedge clk_i);
			req_valid_i = 1'b0;
			// busy from the cycle after acceptance
			check_hit("ready_o", 1'b0, ready_o);
			while (!rsp_valid_o)
				@(negedge clk_i);
			check_hit("ready_o", 1'b1, ready_o);
			check_hit("rsp_o.hit", exp_hit, rsp_o.hit);
			check_word("rsp_o.rdata", exp_rdata, rsp_o.rdata);
			// directed entries also pin the hit flag from the table
			if (e.exp_hit != EXP_ANY)
				check_hit("rsp_o.hit", e.exp_hit[0], rsp_o.hit);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: src/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry
`define SET_BITS 4
`define WAYS 4
`define WORD_W 32

// backing memory
// cycles from first sight of a request to the done pulse
`define MEM_LATENCY 3
// word index width, 4 KB of words
`define MEM_IDX_BITS 10

`endif

// File: src/cache_ctrl.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  req_valid_i,
	input  cache_pkg::cache_req_t req_i,
	output logic                  ready_o,
	output logic                  rsp_valid_o,
	output cache_pkg::cache_rsp_t rsp_o,
	input  logic                  hit_i,
	input  cache_pkg::way_t       hit_way_i,
	input  cache_pkg::way_t       victim_way_i,
	input  cache_pkg::word_t      rdata_i,
	output cache_pkg::set_t       set_o,
	output cache_pkg::tag_t       tag_o,
	output logic                  fill_o,
	output logic                  upd_o,
	output cache_pkg::way_t       way_o,
	output cache_pkg::word_t      wdata_o,
	output logic [1:0]            byte_sel_o,
	output logic                  byte_op_o,
	output logic                  touch_o,
	output logic                  mem_req_valid_o,
	output mem_pkg::mem_req_t     mem_req_o,
	input  logic                  mem_done_i,
	input  mem_pkg::mem_word_t    mem_rdata_i
);
	import cache_pkg::*;
	import mem_pkg::*;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	cache_req_t  req_q;
	cache_rsp_t  rsp_q;
	mem_idx_t    mem_idx;
	logic        accept;

	// a new request may arrive in the response cycle
	assign ready_o     = (state_q == IDLE) || (state_q == RESPOND);
	assign accept      = req_valid_i && ready_o;
	assign rsp_valid_o = (state_q == RESPOND);
	assign rsp_o       = rsp_q;

	assign set_o   = req_q.addr[`SET_BITS+1:2];
	assign tag_o   = req_q.addr[`WORD_W-1:`SET_BITS+2];
	assign mem_idx = req_q.addr[`MEM_IDX_BITS+1:2];

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: if (accept) state_d = LOOKUP;
			LOOKUP: begin
				// stores always write through, loads go to memory on a miss
				if (req_q.write)
					state_d = MEM_WRITE;
				else if (hit_i)
					state_d = RESPOND;
				else
					state_d = MEM_READ;
			end
			MEM_READ: if (mem_done_i) state_d = FILL;
			FILL: state_d = RESPOND;
			MEM_WRITE: if (mem_done_i) state_d = RESPOND;
			RESPOND: state_d = accept ? LOOKUP : IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk_i) begin
		if (accept)
			req_q <= req_i;
	end

	// response data, also the fill word after a load miss
	always_ff @(posedge clk_i) begin
		if (state_q == LOOKUP) begin
			rsp_q.hit   <= hit_i;
			rsp_q.rdata <= (hit_i && !req_q.write) ? rdata_i : '0;
		end else if (state_q == MEM_READ && mem_done_i) begin
			rsp_q.rdata <= mem_rdata_i;
		end
	end

	// array strobes
	assign fill_o     = (state_q == FILL);
	assign upd_o      = (state_q == LOOKUP) && hit_i && req_q.write;
	assign touch_o    = ((state_q == LOOKUP) && hit_i) || fill_o;
	assign way_o      = fill_o ? victim_way_i : hit_way_i;
	assign wdata_o    = fill_o ? rsp_q.rdata : req_q.wdata;
	assign byte_op_o  = !fill_o && req_q.byte_op;
	assign byte_sel_o = req_q.addr[1:0];

	assign mem_req_valid_o = (state_q == MEM_READ) || (state_q == MEM_WRITE);

	always_comb begin
		mem_req_o.idx      = mem_idx;
		mem_req_o.wdata    = req_q.wdata;
		mem_req_o.write    = (state_q == MEM_WRITE);
		mem_req_o.byte_op  = req_q.byte_op;
		mem_req_o.byte_sel = req_q.addr[1:0];
	end

	// cpu only issues while ready
	a_req_when_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		req_valid_i |-> ready_o);

	a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		mem_req_valid_o && !mem_done_i |=> mem_req_valid_o && $stable(mem_req_o));

endmodule

// File: src/cache_data_array.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_data_array (
	input  logic             clk_i,
	input  cache_pkg::set_t  set_i,
	input  cache_pkg::way_t  rd_way_i,
	input  logic             wr_i,
	input  cache_pkg::way_t  wr_way_i,
	input  cache_pkg::word_t wdata_i,
	input  logic             byte_op_i,
	input  logic [1:0]       byte_sel_i,
	output cache_pkg::word_t rdata_o
);
	import cache_pkg::*;
	import mem_pkg::*;

	localparam int SETS = 1 << `SET_BITS;

	word_t data_q [SETS][`WAYS];
	word_t cur_word;

	// read follows the hit way of the current set
	assign rdata_o = data_q[set_i][rd_way_i];

	// old contents of the word being written
	assign cur_word = data_q[set_i][wr_way_i];

	// fill or store hit, byte stores touch one lane only
	always_ff @(posedge clk_i) begin
		if (wr_i)
			data_q[set_i][wr_way_i] <= merge_byte(cur_word, wdata_i, byte_op_i, byte_sel_i);
	end

endmodule

// File: src/cache_lru.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_lru (
	input  logic             clk_i,
	input  logic             rst_n_i,
	input  cache_pkg::set_t  set_i,
	input  logic [`WAYS-1:0] valid_i,
	input  logic             touch_i,
	input  cache_pkg::way_t  way_i,
	output cache_pkg::way_t  victim_way_o
);
	import cache_pkg::*;

	localparam int SETS = 1 << `SET_BITS;

	age_t age_q [SETS][`WAYS];

	// scan downwards so the lowest way wins
	// an invalid way takes precedence over age 0
	always_comb begin
		victim_way_o = '0;
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (age_q[set_i][w] == '0)
				victim_way_o = way_t'(w);
		end
		for (int w = `WAYS - 1; w >= 0; w--) begin
			if (!valid_i[w])
				victim_way_o = way_t'(w);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < `WAYS; w++)
					age_q[s][w] <= '0;
			end
		end else if (touch_i) begin
			for (int w = 0; w < `WAYS; w++) begin
				if (way_t'(w) == way_i)
					age_q[set_i][w] <= '1;
				else if (age_q[set_i][w] != '0)
					age_q[set_i][w] <= age_q[set_i][w] - 1'b1;
			end
		end
	end

endmodule

// File: src/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

	// address split is tag | set | byte offset
	typedef logic [`WORD_W-1:0] addr_t;
	typedef logic [`WORD_W-`SET_BITS-3:0] tag_t;
	typedef logic [`SET_BITS-1:0] set_t;
	typedef logic [$clog2(`WAYS)-1:0] way_t;
	// one age per way, 3 is most recent
	typedef logic [$clog2(`WAYS)-1:0] age_t;
	typedef logic [`WORD_W-1:0] word_t;

	// cpu request, held by the controller after acceptance
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  write;
		logic  byte_op;
	} cache_req_t;

	// stores return zero data
	typedef struct packed {
		word_t rdata;
		logic  hit;
	} cache_rsp_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		MEM_READ,
		FILL,
		MEM_WRITE,
		RESPOND
	} ctrl_state_e;

endpackage

// File: src/cache_subsystem.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_subsystem (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  req_valid_i,
	input  cache_pkg::cache_req_t req_i,
	output logic                  ready_o,
	output logic                  rsp_valid_o,
	output cache_pkg::cache_rsp_t rsp_o
);
	import cache_pkg::*;
	import mem_pkg::*;

	// controller to arrays
	logic             hit;
	way_t             hit_way;
	way_t             victim_way;
	way_t             way;
	word_t            cache_rdata;
	word_t            wdata;
	set_t             set;
	tag_t             tag;
	logic             fill;
	logic             upd;
	logic             touch;
	logic             byte_op;
	logic [1:0]       byte_sel;
	logic [`WAYS-1:0] valid;

	// controller to memory
	logic      mem_req_valid;
	logic      mem_done;
	mem_req_t  mem_req;
	mem_word_t mem_rdata;

	cache_ctrl u_ctrl (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.req_valid_i     (req_valid_i),
		.req_i           (req_i),
		.ready_o         (ready_o),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_o           (rsp_o),
		.hit_i           (hit),
		.hit_way_i       (hit_way),
		.victim_way_i    (victim_way),
		.rdata_i         (cache_rdata),
		.set_o           (set),
		.tag_o           (tag),
		.fill_o          (fill),
		.upd_o           (upd),
		.way_o           (way),
		.wdata_o         (wdata),
		.byte_sel_o      (byte_sel),
		.byte_op_o       (byte_op),
		.touch_o         (touch),
		.mem_req_valid_o (mem_req_valid),
		.mem_req_o       (mem_req),
		.mem_done_i      (mem_done),
		.mem_rdata_i     (mem_rdata)
	);

	cache_tag_array u_tags (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.set_i     (set),
		.tag_i     (tag),
		.fill_i    (fill),
		.way_i     (way),
		.hit_o     (hit),
		.hit_way_o (hit_way),
		.valid_o   (valid)
	);

	// one write port serves both fills and store hits
	cache_data_array u_data (
		.clk_i      (clk_i),
		.set_i      (set),
		.rd_way_i   (hit_way),
		.wr_i       (fill || upd),
		.wr_way_i   (way),
		.wdata_i    (wdata),
		.byte_op_i  (byte_op),
		.byte_sel_i (byte_sel),
		.rdata_o    (cache_rdata)
	);

	cache_lru u_lru (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.set_i        (set),
		.valid_i      (valid),
		.touch_i      (touch),
		.way_i        (way),
		.victim_way_o (victim_way)
	);

	main_memory u_mem (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.req_valid_i (mem_req_valid),
		.req_i       (mem_req),
		.done_o      (mem_done),
		.rdata_o     (mem_rdata)
	);

endmodule

// File: src/cache_tag_array.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module cache_tag_array (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  cache_pkg::set_t    set_i,
	input  cache_pkg::tag_t    tag_i,
	input  logic               fill_i,
	input  cache_pkg::way_t    way_i,
	output logic               hit_o,
	output cache_pkg::way_t    hit_way_o,
	output logic [`WAYS-1:0]   valid_o
);
	import cache_pkg::*;

	localparam int SETS = 1 << `SET_BITS;

	tag_t             tag_q [SETS][`WAYS];
	logic [`WAYS-1:0] valid_q [SETS];
	logic [`WAYS-1:0] match;

	// all ways compared at once
	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < `WAYS; w++) begin
			match[w] = valid_q[set_i][w] && (tag_q[set_i][w] == tag_i);
			if (match[w])
				hit_way_o = way_t'(w);
		end
	end

	assign hit_o   = |match;
	assign valid_o = valid_q[set_i];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int s = 0; s < SETS; s++)
				valid_q[s] <= '0;
		end else if (fill_i) begin
			valid_q[set_i][way_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (fill_i)
			tag_q[set_i][way_i] <= tag_i;
	end

	// fills only go to missing tags, so a tag never sits in two ways
	a_single_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(match));

endmodule

// File: src/main_memory.sv
`timescale 1ns/1ps
`include "cache_config.svh"

module main_memory (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               req_valid_i,
	input  mem_pkg::mem_req_t  req_i,
	output logic               done_o,
	output mem_pkg::mem_word_t rdata_o
);
	import mem_pkg::*;

	localparam int DEPTH = 1 << `MEM_IDX_BITS;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	mem_word_t        mem_q [DEPTH];
	logic [CNT_W-1:0] cnt_q;
	logic             busy_q;

	assign done_o  = busy_q && (cnt_q == CNT_W'(`MEM_LATENCY));
	// request is held stable, so a direct read is valid at done
	assign rdata_o = mem_q[req_i.idx];

	// latency counter, starts at 1 on the first cycle seen
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (done_o) begin
			busy_q <= 1'b0;
			cnt_q  <= '0;
		end else if (busy_q) begin
			cnt_q <= cnt_q + 1'b1;
		end else if (req_valid_i) begin
			busy_q <= 1'b1;
			cnt_q  <= CNT_W'(1);
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < DEPTH; i++)
				mem_q[i] <= '0;
		end else if (done_o && req_i.write) begin
			mem_q[req_i.idx] <= merge_byte(mem_q[req_i.idx], req_i.wdata, req_i.byte_op,
				req_i.byte_sel);
		end
	end

	// done only for a request that has been waiting the full latency
	a_done_pending: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		done_o |-> req_valid_i && $past(req_valid_i, `MEM_LATENCY));

endmodule

// File: src/mem_pkg.sv
`include "cache_config.svh"

package mem_pkg;

	typedef logic [`MEM_IDX_BITS-1:0] mem_idx_t;
	typedef logic [`WORD_W-1:0] mem_word_t;

	// held stable by the requester until done
	typedef struct packed {
		mem_idx_t  idx;
		mem_word_t wdata;
		logic      write;
		logic      byte_op;
		logic [1:0] byte_sel;
	} mem_req_t;

	// byte stores take the lane data from wdata[7:0]
	function automatic mem_word_t merge_byte(mem_word_t old_w, mem_word_t new_w,
			logic byte_op, logic [1:0] byte_sel);
		mem_word_t res;
		res = old_w;
		if (byte_op)
			res[byte_sel*8 +: 8] = new_w[7:0];
		else
			res = new_w;
		return res;
	endfunction

endpackage
